/* rtl/fractal_defines.svh */
`ifndef FRACTAL_DEFINES_SVH
`define FRACTAL_DEFINES_SVH

// ====================
// VGA raster, 640x480 at 25 MHz
`define H_VISIBLE 640
`define H_FRONT   16
`define H_SYNC    96
`define H_TOTAL   800

`define V_VISIBLE 480
`define V_FRONT   10
`define V_SYNC    2
`define V_TOTAL   525

// ====================
// Rendered image and frame buffer
`define IMG_W     320
`define IMG_H     240
`define FB_ADDR_W 17    // Holds IMG_W*IMG_H addresses
`define ITER_W    8
`define MAX_ITER  32

// ====================
// Q16.16 view window
`define COORD_W   32
`define FRAC_BITS 16
`define CX_MIN    (-131072)    // -2.0
`define CX_MAX    (65536)      // 1.0
`define CY_MIN    (-78643)     // -1.2
`define CY_MAX    (78643)      // 1.2

`endif

/* rtl/fractal_display_top.sv */
`include "fractal_defines.svh"

module fractal_display_top import fractal_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  logic       anim_en,
    input  logic [1:0] speed_sel,
    output vga_out_t   vga
);
    raster_t            raster;
    logic               frame_start;
    pix_req_t           pix_req;
    pix_res_t           pix_res;
    logic               core_busy;
    fb_write_t          fb_wr;
    logic               frame_done;
    logic               render_start;
    logic [`ITER_W-1:0] pix_count;
    logic               show;

    // ====================
    // Raster and render side
    vga_timing vga_timing_i (
        .clk         (clk),
        .resetn      (resetn),
        .raster      (raster),
        .frame_start (frame_start)
    );

    mandel_core mandel_core_i (
        .clk    (clk),
        .resetn (resetn),
        .req    (pix_req),
        .busy   (core_busy),
        .res    (pix_res)
    );

    frame_renderer frame_renderer_i (
        .clk          (clk),
        .resetn       (resetn),
        .render_start (render_start),
        .busy         (core_busy),
        .req          (pix_req),
        .res          (pix_res),
        .fb_wr        (fb_wr),
        .frame_done   (frame_done)
    );

    // ====================
    // Buffering and output
    pingpong_buffer pingpong_buffer_i (
        .clk          (clk),
        .resetn       (resetn),
        .fb_wr        (fb_wr),
        .frame_done   (frame_done),
        .frame_start  (frame_start),
        .raster       (raster),
        .render_start (render_start),
        .pix_count    (pix_count),
        .show         (show)
    );

    palette_stage palette_stage_i (
        .clk         (clk),
        .resetn      (resetn),
        .raster      (raster),
        .frame_start (frame_start),
        .anim_en     (anim_en),
        .speed_sel   (speed_sel),
        .pix_count   (pix_count),
        .show        (show),
        .vga         (vga)
    );

endmodule

/* rtl/fractal_pkg.sv */
`include "fractal_defines.svh"

package fractal_pkg;

    // Position inside the 320x240 image
    typedef struct packed {
        logic [9:0] x;
        logic [8:0] y;
    } pix_pos_t;

    typedef struct packed {
        logic     valid;
        pix_pos_t pos;
    } pix_req_t;

    typedef struct packed {
        logic              valid;
        logic [`ITER_W-1:0] count;
    } pix_res_t;

    typedef struct packed {
        logic                 en;
        logic [`FB_ADDR_W-1:0] addr;
        logic [`ITER_W-1:0]    data;
    } fb_write_t;

    // Syncs are active low
    typedef struct packed {
        logic     hsync;
        logic     vsync;
        logic     active;    // Inside the centred window
        pix_pos_t pos;
    } raster_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic blank_n;
        rgb_t rgb;
    } vga_out_t;

    typedef enum logic [1:0] {CORE_IDLE, CORE_MAP, CORE_ITER} core_state_e;
    typedef enum logic [1:0] {REN_IDLE, REN_REQUEST, REN_WAIT} render_state_e;

endpackage

/* rtl/frame_renderer.sv */
`include "fractal_defines.svh"

module frame_renderer import fractal_pkg::*; (
    input  logic      clk,
    input  logic      resetn,
    input  logic      render_start,
    input  logic      busy,
    output pix_req_t  req,
    input  pix_res_t  res,
    output fb_write_t fb_wr,
    output logic      frame_done
);
    render_state_e state;
    logic [9:0]    x;
    logic [8:0]    y;
    logic          last_col;
    logic          last_pixel;

    assign last_col   = (x == 10'(`IMG_W - 1));
    assign last_pixel = last_col && (y == 9'(`IMG_H - 1));

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state      <= REN_IDLE;
            x          <= '0;
            y          <= '0;
            req        <= '0;
            fb_wr      <= '0;
            frame_done <= 1'b0;
        end else begin
            req.valid  <= 1'b0;
            fb_wr.en   <= 1'b0;
            frame_done <= 1'b0;
            case (state)
                REN_IDLE: begin
                    if (render_start) begin
                        x     <= '0;
                        y     <= '0;
                        state <= REN_REQUEST;
                    end
                end
                REN_REQUEST: begin
                    if (!busy) begin
                        req.valid <= 1'b1;
                        req.pos.x <= x;
                        req.pos.y <= y;
                        state     <= REN_WAIT;
                    end
                end
                REN_WAIT: begin
                    if (res.valid) begin
                        fb_wr.en   <= 1'b1;
                        fb_wr.addr <= `FB_ADDR_W'(y) * `FB_ADDR_W'(`IMG_W) + `FB_ADDR_W'(x);
                        fb_wr.data <= res.count;
                        if (last_pixel) begin
                            frame_done <= 1'b1;
                            state      <= REN_IDLE;
                        end else begin
                            state <= REN_REQUEST;
                            x     <= last_col ? '0 : x + 10'd1;    // Raster order
                            if (last_col) y <= y + 9'd1;
                        end
                    end
                end
                default: state <= REN_IDLE;
            endcase
        end
    end

    a_res_in_wait: assert property (@(posedge clk) disable iff (!resetn)
        res.valid |-> state == REN_WAIT);

endmodule

/* rtl/mandel_core.sv */
`include "fractal_defines.svh"

module mandel_core import fractal_pkg::*; (
    input  logic     clk,
    input  logic     resetn,
    input  pix_req_t req,
    output logic     busy,
    output pix_res_t res
);
    localparam logic signed [63:0] CX_RANGE  = `CX_MAX - `CX_MIN;
    localparam logic signed [63:0] CY_RANGE  = `CY_MAX - `CY_MIN;
    localparam logic signed [63:0] ESC_LIMIT = 64'sd4 <<< (2 * `FRAC_BITS);  // 4.0 in Q32.32

    core_state_e               state;
    logic [`ITER_W-1:0]        iter;
    pix_pos_t                  pos_q;
    logic signed [`COORD_W-1:0] c_re;
    logic signed [`COORD_W-1:0] c_im;
    logic signed [`COORD_W-1:0] z_re;
    logic signed [`COORD_W-1:0] z_im;
    logic signed [63:0]        c_re_map;
    logic signed [63:0]        c_im_map;
    logic signed [63:0]        zr_sq;
    logic signed [63:0]        zi_sq;
    logic signed [63:0]        zr_zi;
    logic signed [63:0]        mag2;
    logic signed [63:0]        zr_next;
    logic signed [63:0]        zi_next;

    // ====================
    // Pixel to complex plane
    assign c_re_map = `CX_MIN + (CX_RANGE * $signed(64'(pos_q.x))) / (`IMG_W - 1);
    assign c_im_map = `CY_MIN + (CY_RANGE * $signed(64'(pos_q.y))) / (`IMG_H - 1);

    // Products are Q32.32
    assign zr_sq   = z_re * z_re;
    assign zi_sq   = z_im * z_im;
    assign zr_zi   = z_re * z_im;
    assign mag2    = zr_sq + zi_sq;
    assign zr_next = ((zr_sq - zi_sq) >>> `FRAC_BITS) + c_re;
    assign zi_next = (zr_zi >>> (`FRAC_BITS - 1)) + c_im;    // 2*re*im back to Q16.16

    assign busy = (state != CORE_IDLE);

    // ====================
    // Control
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state <= CORE_IDLE;
            iter  <= '0;
            res   <= '0;
        end else begin
            res.valid <= 1'b0;
            case (state)
                CORE_IDLE: begin
                    if (req.valid) state <= CORE_MAP;
                end
                CORE_MAP: begin
                    iter  <= '0;
                    state <= CORE_ITER;
                end
                CORE_ITER: begin
                    if (mag2 > ESC_LIMIT) begin
                        res.valid <= 1'b1;
                        res.count <= iter;
                        state     <= CORE_IDLE;
                    end else if (iter == `ITER_W'(`MAX_ITER - 1)) begin
                        res.valid <= 1'b1;    // Treated as inside the set
                        res.count <= `ITER_W'(`MAX_ITER);
                        state     <= CORE_IDLE;
                    end else begin
                        iter <= iter + 1'b1;
                    end
                end
                default: state <= CORE_IDLE;
            endcase
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        if (state == CORE_IDLE && req.valid) pos_q <= req.pos;
        if (state == CORE_MAP) begin
            c_re <= c_re_map[`COORD_W-1:0];
            c_im <= c_im_map[`COORD_W-1:0];
            z_re <= '0;
            z_im <= '0;
        end else if (state == CORE_ITER) begin
            z_re <= zr_next[`COORD_W-1:0];
            z_im <= zi_next[`COORD_W-1:0];
        end
    end

    a_no_req_busy: assert property (@(posedge clk) disable iff (!resetn)
        req.valid |-> !busy);

endmodule

/* rtl/palette_stage.sv */
`include "fractal_defines.svh"

module palette_stage import fractal_pkg::*; (
    input  logic               clk,
    input  logic               resetn,
    input  raster_t            raster,
    input  logic               frame_start,
    input  logic               anim_en,
    input  logic [1:0]         speed_sel,
    input  logic [`ITER_W-1:0] pix_count,
    input  logic               show,
    output vga_out_t           vga
);
    logic [7:0] phase;
    logic [7:0] step;
    logic [7:0] index;
    logic [7:0] idx_g;
    logic [7:0] idx_b;
    logic       hsync_q;
    logic       vsync_q;
    logic       active_q;
    rgb_t       colour;

    assign step  = 8'd1 << speed_sel;    // 1, 2, 4 or 8
    assign index = 8'(pix_count) + phase;
    assign idx_g = index + 8'd85;
    assign idx_b = index + 8'd170;

    // Rainbow, channels a third of a turn apart
    assign colour = '{red:   {index[7:2], 2'b00},
                      green: {idx_g[7:2], 2'b00},
                      blue:  {idx_b[7:2], 2'b00}};

    // ====================
    // Phase, sync delay and output register
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            phase    <= '0;
            hsync_q  <= 1'b1;
            vsync_q  <= 1'b1;
            active_q <= 1'b0;
            vga      <= '{hsync: 1'b1, vsync: 1'b1, blank_n: 1'b0, rgb: '0};
        end else begin
            if (frame_start && anim_en) phase <= phase + step;
            hsync_q     <= raster.hsync;    // Matches the memory read
            vsync_q     <= raster.vsync;
            active_q    <= raster.active;
            vga.hsync   <= hsync_q;
            vga.vsync   <= vsync_q;
            vga.blank_n <= active_q;
            vga.rgb     <= show ? colour : '0;
        end
    end

endmodule

/* rtl/pingpong_buffer.sv */
`include "fractal_defines.svh"

module pingpong_buffer import fractal_pkg::*; (
    input  logic               clk,
    input  logic               resetn,
    input  fb_write_t          fb_wr,
    input  logic               frame_done,
    input  logic               frame_start,
    input  raster_t            raster,
    output logic               render_start,
    output logic [`ITER_W-1:0] pix_count,
    output logic               show
);
    localparam int FB_DEPTH = `IMG_W * `IMG_H;

    logic [`ITER_W-1:0]    mem [0:1][0:FB_DEPTH-1];
    logic [`FB_ADDR_W-1:0] raddr;
    logic                  wr_sel;
    logic                  disp_sel;
    logic                  ready;         // A finished frame is on display
    logic                  swap_pending;
    logic                  rendering;

    assign raddr = `FB_ADDR_W'(raster.pos.y) * `FB_ADDR_W'(`IMG_W) + `FB_ADDR_W'(raster.pos.x);

    // ====================
    // Frame memories
    always_ff @(posedge clk) begin
        if (fb_wr.en) mem[wr_sel][fb_wr.addr] <= fb_wr.data;
        pix_count <= mem[disp_sel][raddr];
    end

    // ====================
    // Buffer selection and swap
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            wr_sel       <= 1'b0;
            disp_sel     <= 1'b1;    // First swap shows buffer 0
            ready        <= 1'b0;
            swap_pending <= 1'b0;
            rendering    <= 1'b0;
            render_start <= 1'b0;
            show         <= 1'b0;
        end else begin
            show <= raster.active && ready;    // Lines up with the read

            // Renderer is idle when this rises, so it is taken at once
            if (render_start) render_start <= 1'b0;

            // Swap in vertical blanking only
            if (frame_start) begin
                if (swap_pending) begin
                    disp_sel     <= ~disp_sel;
                    ready        <= 1'b1;
                    swap_pending <= 1'b0;
                end
                if (!rendering) begin
                    render_start <= 1'b1;
                    rendering    <= 1'b1;
                end
            end

            if (frame_done) begin
                wr_sel       <= ~wr_sel;
                swap_pending <= 1'b1;
                rendering    <= 1'b0;
            end
        end
    end

    a_no_write_shown: assert property (@(posedge clk) disable iff (!resetn)
        fb_wr.en && ready |-> wr_sel != disp_sel);

endmodule

/* rtl/vga_timing.sv */
`include "fractal_defines.svh"

module vga_timing import fractal_pkg::*; (
    input  logic    clk,
    input  logic    resetn,
    output raster_t raster,
    output logic    frame_start
);
    localparam int H_OFF    = (`H_VISIBLE - `IMG_W) / 2;    // 160
    localparam int V_OFF    = (`V_VISIBLE - `IMG_H) / 2;    // 120
    localparam int HS_BEGIN = `H_VISIBLE + `H_FRONT;
    localparam int VS_BEGIN = `V_VISIBLE + `V_FRONT;

    logic [9:0] hcount;
    logic [9:0] vcount;
    logic       in_window;
    logic [9:0] hrel;
    logic [9:0] vrel;

    // ====================
    // Raster counters
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            hcount <= '0;
            vcount <= '0;
        end else if (hcount == 10'(`H_TOTAL - 1)) begin
            hcount <= '0;
            vcount <= (vcount == 10'(`V_TOTAL - 1)) ? '0 : vcount + 10'd1;
        end else begin
            hcount <= hcount + 10'd1;
        end
    end

    assign in_window = (hcount >= 10'(H_OFF)) && (hcount < 10'(H_OFF + `IMG_W)) &&
                       (vcount >= 10'(V_OFF)) && (vcount < 10'(V_OFF + `IMG_H));
    assign hrel = hcount - 10'(H_OFF);
    assign vrel = vcount - 10'(V_OFF);

    // ====================
    // Registered raster state, one clock behind the counters
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            raster      <= '{hsync: 1'b1, vsync: 1'b1, active: 1'b0, pos: '0};
            frame_start <= 1'b0;
        end else begin
            raster.hsync  <= !((hcount >= 10'(HS_BEGIN)) && (hcount < 10'(HS_BEGIN + `H_SYNC)));
            raster.vsync  <= !((vcount >= 10'(VS_BEGIN)) && (vcount < 10'(VS_BEGIN + `V_SYNC)));
            raster.active <= in_window;
            raster.pos.x  <= in_window ? hrel : '0;
            raster.pos.y  <= in_window ? vrel[8:0] : '0;
            // First clock of the vsync pulse
            frame_start   <= (hcount == '0) && (vcount == 10'(VS_BEGIN));
        end
    end

    a_window_x: assert property (@(posedge clk) disable iff (!resetn)
        raster.active |-> raster.pos.x < 10'(`IMG_W));

endmodule

/* verification/display_checker.sv */
`include "fractal_defines.svh"

module display_checker import fractal_pkg::*; (
    input  logic               clk,
    input  logic               resetn,
    input  vga_out_t           vga,
    input  logic [7:0]         phase_step,    // Added to the phase at each vsync pulse
    input  logic               sample_wr,
    input  pix_pos_t           sample_pos,
    input  logic [`ITER_W-1:0] sample_count,
    output int                 errors,
    output int                 vsyncs,
    output int                 lit_frames
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_SAMPLES = 16;

    pix_pos_t           samp_pos [0:MAX_SAMPLES-1];
    logic [`ITER_W-1:0] samp_cnt [0:MAX_SAMPLES-1];
    int                 num_samples = 0;

    logic       prev_hs;
    logic       prev_vs;
    logic       prev_bl;
    logic       seen_hs;
    logic       seen_vs;
    int         h_clks;
    int         hs_low;
    int         v_clks;
    int         vs_low;
    int         col;         // Clocks since blank_n rose
    int         row;         // Window lines finished in this frame
    logic       any_lit;
    logic       any_dark;
    logic [7:0] phase;
    int         err_cnt;
    int         vs_cnt;
    int         lit_cnt;

    always @(posedge clk) begin
        if (sample_wr && num_samples < MAX_SAMPLES) begin
            samp_pos[num_samples] <= sample_pos;
            samp_cnt[num_samples] <= sample_count;
            num_samples           <= num_samples + 1;
        end
    end

    // Top six bits of each channel index, low two bits zero
    function automatic rgb_t expected_colour(input logic [7:0] count, input logic [7:0] ph);
        logic [7:0] idx;
        rgb_t       c;
        idx     = count + ph;
        c.red   = idx & 8'hfc;
        c.green = (idx + 8'd85) & 8'hfc;
        c.blue  = (idx + 8'd170) & 8'hfc;
        return c;
    endfunction

    task automatic value_error(input string name, input int got, input int exp);
        $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        err_cnt++;
    endtask

    task automatic check_samples();
        rgb_t want;
        for (int i = 0; i < num_samples; i++) begin
            if (samp_pos[i].x == col && samp_pos[i].y == row) begin
                want = expected_colour(samp_cnt[i], phase);
                if (vga.rgb !== want) begin
                    $display("** Error at %0t: vga.rgb at (%0d,%0d) = %h, expected %h",
                             $time, col, row, vga.rgb, want);
                    err_cnt++;
                end
            end
        end
    endtask

    always @(posedge clk) begin
        if (!resetn) begin
            prev_hs  = 1'b1;
            prev_vs  = 1'b1;
            prev_bl  = 1'b0;
            seen_hs  = 1'b0;
            seen_vs  = 1'b0;
            h_clks   = 0;
            hs_low   = 0;
            v_clks   = 0;
            vs_low   = 0;
            col      = 0;
            row      = 0;
            any_lit  = 1'b0;
            any_dark = 1'b0;
            phase    = 8'd0;
            err_cnt  = 0;
            vs_cnt   = 0;
            lit_cnt  = 0;
        end else begin
            h_clks++;
            v_clks++;

            // ====================
            // Sync periods and pulse widths
            if (prev_hs && !vga.hsync) begin
                if (seen_hs && h_clks != `H_TOTAL)
                    value_error("vga.hsync period", h_clks, `H_TOTAL);
                seen_hs = 1'b1;
                h_clks  = 0;
                hs_low  = 0;
            end
            if (!vga.hsync) hs_low++;
            if (!prev_hs && vga.hsync && seen_hs && hs_low != `H_SYNC)
                value_error("vga.hsync low clocks", hs_low, `H_SYNC);

            if (prev_vs && !vga.vsync) begin
                if (seen_vs && v_clks != `H_TOTAL * `V_TOTAL)
                    value_error("vga.vsync period", v_clks, `H_TOTAL * `V_TOTAL);
                if (row != `IMG_H)
                    value_error("vga.blank_n lines per frame", row, `IMG_H);
                // Rendering starts at the first vsync pulse and takes more than a frame
                if (vs_cnt < 2 && any_lit) begin
                    $display("Error at %0t: frame %0d after reset is not black", $time, vs_cnt);
                    err_cnt++;
                end
                // A frame is all black or all coloured
                if (any_lit && any_dark) begin
                    $display("Error at %0t: frame mixes black and coloured pixels", $time);
                    err_cnt++;
                end else if (any_lit) begin
                    lit_cnt++;
                end else if (lit_cnt > 0) begin
                    $display("Error at %0t: black frame after a coloured frame", $time);
                    err_cnt++;
                end
                any_lit  = 1'b0;
                any_dark = 1'b0;
                row      = 0;
                phase    = phase + phase_step;    // Next frame uses the new phase
                vs_cnt++;
                seen_vs  = 1'b1;
                v_clks   = 0;
                vs_low   = 0;
            end
            if (!vga.vsync) vs_low++;
            if (!prev_vs && vga.vsync && seen_vs && vs_low != `H_TOTAL * `V_SYNC)
                value_error("vga.vsync low clocks", vs_low, `H_TOTAL * `V_SYNC);

            // ====================
            // Window and border
            if (vga.blank_n) begin
                if (!prev_bl) col = 0;
                if (vga.rgb !== '0) begin
                    any_lit = 1'b1;
                    check_samples();
                end else begin
                    any_dark = 1'b1;
                end
                col++;
            end else begin
                if (vga.rgb !== '0) begin
                    $display("** Error at %0t: vga.rgb = %h with blank_n low, expected 0",
                             $time, vga.rgb);
                    err_cnt++;
                end
                if (prev_bl) begin
                    if (col != `IMG_W) value_error("vga.blank_n high clocks", col, `IMG_W);
                    row++;
                end
            end

            prev_hs = vga.hsync;
            prev_vs = vga.vsync;
            prev_bl = vga.blank_n;
        end
        errors     <= err_cnt;
        vsyncs     <= vs_cnt;
        lit_frames <= lit_cnt;
    end

endmodule

/* verification/fractal_display_tb.sv */
`include "fractal_defines.svh"

module fractal_display_tb import fractal_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int FRAME_CLKS = `H_TOTAL * `V_TOTAL;
    localparam int IMG_PIXELS = `IMG_W * `IMG_H;

    logic               clk;
    logic               resetn;
    logic               anim_en;
    logic [1:0]         speed_sel;
    vga_out_t           vga;
    logic [7:0]         phase_step;
    logic               sample_wr;
    pix_pos_t           sample_pos;
    logic [`ITER_W-1:0] sample_count;
    int                 errors;
    int                 vsyncs;
    int                 lit_frames;

    int   samp_x[$];
    int   samp_y[$];
    int   samp_c[$];
    int   anim_speed[$];
    int   anim_frames[$];
    int   data_frames;
    logic data_ok;
    logic data_loaded;
    int   errors_at_start;
    int   tests_run;
    int   tests_failed;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    fractal_display_top fractal_display_top_i (
        .clk       (clk),
        .resetn    (resetn),
        .anim_en   (anim_en),
        .speed_sel (speed_sel),
        .vga       (vga)
    );

    display_checker display_checker_i (
        .clk          (clk),
        .resetn       (resetn),
        .vga          (vga),
        .phase_step   (phase_step),
        .sample_wr    (sample_wr),
        .sample_pos   (sample_pos),
        .sample_count (sample_count),
        .errors       (errors),
        .vsyncs       (vsyncs),
        .lit_frames   (lit_frames)
    );

    // ====================
    // Data file
    task automatic read_testdata();
        int fd;
        int ch;
        int n;
        int a;
        int b;
        int c;
        fd = $fopen("verification/fractal_testdata.txt", "r");
        if (fd == 0) begin
            $display("Error: cannot open verification/fractal_testdata.txt");
            data_ok = 1'b0;
        end else begin
            ch = $fgetc(fd);
            while (ch != -1) begin
                if (ch == "#") begin
                    while (ch != 10 && ch != -1) ch = $fgetc(fd);    // Skip comment line
                end else if (ch == "S") begin
                    n = $fscanf(fd, "%d %d %d", a, b, c);
                    if (n != 3 || a >= `IMG_W || b >= `IMG_H) data_ok = 1'b0;
                    samp_x.push_back(a);
                    samp_y.push_back(b);
                    samp_c.push_back(c);
                end else if (ch == "A") begin
                    n = $fscanf(fd, "%d %d", a, b);
                    if (n != 2 || a > 3 || b < 1) data_ok = 1'b0;
                    anim_speed.push_back(a);
                    anim_frames.push_back(b);
                    data_frames += b;
                end
                ch = $fgetc(fd);
            end
            $fclose(fd);
            if (samp_x.size() == 0 || samp_x.size() > 16 || anim_speed.size() == 0)
                data_ok = 1'b0;
            if (!data_ok) $display("Error: bad or missing records in the data file");
        end
    endtask

    task automatic load_samples();
        for (int i = 0; i < samp_x.size(); i++) begin
            @(posedge clk);
            sample_wr    <= 1'b1;
            sample_pos   <= '{x: 10'(samp_x[i]), y: 9'(samp_y[i])};
            sample_count <= `ITER_W'(samp_c[i]);
        end
        @(posedge clk);
        sample_wr <= 1'b0;
    endtask

    task automatic wait_vsyncs(input int n);
        int target;
        target = vsyncs + n;
        while (vsyncs < target) @(posedge clk);
    endtask

    // Far from vsync
    task automatic wait_window();
        @(posedge clk);
        while (!vga.blank_n) @(posedge clk);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != errors_at_start) begin
            tests_failed++;
            $display("Test %0d, %s: FAIL, %0d errors", tests_run, name, errors - errors_at_start);
        end else begin
            $display("Test %0d, %s: PASS", tests_run, name);
        end
        errors_at_start = errors;
    endtask

    // ====================
    // Watchdog, worst-case render plus every frame of the run
    initial begin
        wait (data_loaded);
        repeat (IMG_PIXELS * (`MAX_ITER + 3) + FRAME_CLKS * (data_frames + 4)) @(posedge clk);
        $display("Timeout: the run did not finish within the allowed clock cycles");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        resetn          = 1'b0;
        anim_en         = 1'b0;
        speed_sel       = 2'd0;
        phase_step      = 8'd0;
        sample_wr       = 1'b0;
        sample_pos      = '0;
        sample_count    = '0;
        data_ok         = 1'b1;
        data_loaded     = 1'b0;
        data_frames     = 0;
        errors_at_start = 0;
        tests_run       = 0;
        tests_failed    = 0;
        $timeformat(-9, 1, " ns", 10);
        read_testdata();
        data_loaded = 1'b1;
        repeat (5) @(posedge clk);
        resetn <= 1'b1;

        if (data_ok) begin
            load_samples();
            while (lit_frames < 1) @(posedge clk);    // First coloured frame is at phase 0
            end_test("black startup frames, then fractal values at phase 0");
            for (int i = 0; i < anim_speed.size(); i++) begin
                wait_window();
                anim_en    <= 1'b1;
                speed_sel  <= 2'(anim_speed[i]);
                phase_step <= 8'd1 << anim_speed[i];
                wait_vsyncs(anim_frames[i]);
                end_test($sformatf("animation speed %0d for %0d frames",
                                   anim_speed[i], anim_frames[i]));
            end
            wait_window();
            anim_en    <= 1'b0;
            phase_step <= 8'd0;
            wait_vsyncs(1);
            end_test("animation off, last phase held");
        end

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors, %0d coloured frames",
                 tests_run, tests_run - tests_failed, tests_failed, errors, lit_frames);
        if (data_ok && tests_failed == 0 && errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* verification/fractal_testdata.txt */
# S x y count : pixel (x, y) of the 320x240 image and its expected iteration count
# A speed frames : animation on with speed_sel = speed for that many vsync pulses
S 0 0 1
S 319 0 2
S 160 0 3
S 0 120 1
S 280 120 4
S 300 120 3
S 160 120 32
S 213 120 32
S 319 239 2
A 0 2
A 1 1
A 3 2
A 2 1

/* verilog.f */
+incdir+rtl
rtl/fractal_pkg.sv
rtl/vga_timing.sv
rtl/mandel_core.sv
rtl/frame_renderer.sv
rtl/pingpong_buffer.sv
rtl/palette_stage.sv
rtl/fractal_display_top.sv
verification/display_checker.sv
verification/fractal_display_tb.sv
